// File: hdl/fft_pkg.sv
package fft_pkg;

  ////////////////////////////////////////////////////////////
  // Datapath widths, per real or imaginary component
  ////////////////////////////////////////////////////////////

  // Input samples
  localparam int IN_W  = 10;
  // Stage 0 butterfly grows one bit
  localparam int BF0_W = 11;
  // Stage 0 rotation adds one more bit
  localparam int S0_W  = 12;
  localparam int BF1_W = 13;
  localparam int S1_W  = 14;
  // Saturated output
  localparam int OUT_W = 12;

  // Twiddles are signed Q1.9
  localparam int COEFF_W    = 11;
  localparam int COEFF_FRAC = 9;

  ////////////////////////////////////////////////////////////
  // Frame geometry
  ////////////////////////////////////////////////////////////

  localparam int FFT_POINTS = 16;
  // Two samples per clock, so half a frame of pairs
  localparam int PAIRS      = FFT_POINTS / 2;
  // Stage 1 combines samples 4 pairs apart
  localparam int COMM_DEPTH = 4;

  ////////////////////////////////////////////////////////////
  // W16^k for k = 0..7, scaled by 2^COEFF_FRAC
  ////////////////////////////////////////////////////////////

  // round(512 * cos(2*pi*k/16))
  localparam logic signed [COEFF_W-1:0] TW_RE [PAIRS] = '{
    11'sd512, 11'sd473, 11'sd362, 11'sd196,
    11'sd0, -11'sd196, -11'sd362, -11'sd473
  };

  // round(-512 * sin(2*pi*k/16))
  localparam logic signed [COEFF_W-1:0] TW_IM [PAIRS] = '{
    11'sd0, -11'sd196, -11'sd362, -11'sd473,
    -11'sd512, -11'sd473, -11'sd362, -11'sd196
  };

  // Commutator fill tracking in the stage control
  typedef enum logic [1:0] {
    FRAME_IDLE,
    FRAME_FILL,
    FRAME_RUN
  } frame_state_t;

endpackage

// File: hdl/fft_cmult_round.sv
`timescale 1ns/10ps

module fft_cmult_round #(
  parameter int DATA_W = 11
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               in_valid,
  input  logic signed [DATA_W-1:0]           x_re,
  input  logic signed [DATA_W-1:0]           x_im,
  input  logic signed [fft_pkg::COEFF_W-1:0] w_re,
  input  logic signed [fft_pkg::COEFF_W-1:0] w_im,
  output logic signed [DATA_W:0]             y_re,
  output logic signed [DATA_W:0]             y_im,
  output logic                               out_valid
);

  // Full precision partial products
  logic signed [DATA_W+fft_pkg::COEFF_W-1:0] p_rr;
  logic signed [DATA_W+fft_pkg::COEFF_W-1:0] p_ii;
  logic signed [DATA_W+fft_pkg::COEFF_W-1:0] p_ri;
  logic signed [DATA_W+fft_pkg::COEFF_W-1:0] p_ir;
  logic signed [DATA_W+fft_pkg::COEFF_W:0]   acc_re;
  logic signed [DATA_W+fft_pkg::COEFF_W:0]   acc_im;
  logic signed [DATA_W+fft_pkg::COEFF_W:0]   half_lsb;
  logic signed [DATA_W+fft_pkg::COEFF_W:0]   rnd_re;
  logic signed [DATA_W+fft_pkg::COEFF_W:0]   rnd_im;

  assign p_rr = x_re * w_re;
  assign p_ii = x_im * w_im;
  assign p_ri = x_re * w_im;
  assign p_ir = x_im * w_re;

  assign acc_re = p_rr - p_ii;
  assign acc_im = p_ri + p_ir;

  // Half an output LSB, so the shift below rounds half up
  assign half_lsb = {{(DATA_W + fft_pkg::COEFF_W - fft_pkg::COEFF_FRAC + 1){1'b0}}, 1'b1,
                     {(fft_pkg::COEFF_FRAC - 1){1'b0}}};
  assign rnd_re = acc_re + half_lsb;
  assign rnd_im = acc_im + half_lsb;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  // Dropping COEFF_FRAC bits is the arithmetic shift back to data scale
  always_ff @(posedge clk) begin
    if (in_valid) begin
      y_re <= rnd_re[fft_pkg::COEFF_FRAC +: DATA_W+1];
      y_im <= rnd_im[fft_pkg::COEFF_FRAC +: DATA_W+1];
    end
  end

endmodule

// File: hdl/fft_input_stage.sv
`timescale 1ns/10ps

module fft_input_stage (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            in_valid,
  input  logic signed [fft_pkg::IN_W-1:0] in_a_re,
  input  logic signed [fft_pkg::IN_W-1:0] in_a_im,
  input  logic signed [fft_pkg::IN_W-1:0] in_b_re,
  input  logic signed [fft_pkg::IN_W-1:0] in_b_im,
  output logic                            s0_valid,
  output logic signed [fft_pkg::S0_W-1:0] s0_a_re,
  output logic signed [fft_pkg::S0_W-1:0] s0_a_im,
  output logic signed [fft_pkg::S0_W-1:0] s0_b_re,
  output logic signed [fft_pkg::S0_W-1:0] s0_b_im
);

  // Pair index n within the frame, wraps at PAIRS
  logic [$clog2(fft_pkg::PAIRS)-1:0] pair_idx;
  logic [$clog2(fft_pkg::PAIRS)-1:0] bf_idx;
  logic                              bf_valid;

  logic signed [fft_pkg::BF0_W-1:0] bf_sum_re;
  logic signed [fft_pkg::BF0_W-1:0] bf_sum_im;
  logic signed [fft_pkg::BF0_W-1:0] bf_dif_re;
  logic signed [fft_pkg::BF0_W-1:0] bf_dif_im;

  ////////////////////////////////////////////////////////////
  // Input register and stage 0 butterfly
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pair_idx <= '0;
      bf_valid <= 1'b0;
    end else begin
      bf_valid <= in_valid;
      if (in_valid) begin
        pair_idx <= pair_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      bf_sum_re <= in_a_re + in_b_re;
      bf_sum_im <= in_a_im + in_b_im;
      bf_dif_re <= in_a_re - in_b_re;
      bf_dif_im <= in_a_im - in_b_im;
      bf_idx    <= pair_idx;
    end
  end

  ////////////////////////////////////////////////////////////
  // Lower lane rotation by W16^n, upper lane delayed to match
  ////////////////////////////////////////////////////////////

  fft_cmult_round #(
    .DATA_W (fft_pkg::BF0_W)
  ) u_rot0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (bf_valid),
    .x_re      (bf_dif_re),
    .x_im      (bf_dif_im),
    .w_re      (fft_pkg::TW_RE[bf_idx]),
    .w_im      (fft_pkg::TW_IM[bf_idx]),
    .y_re      (s0_b_re),
    .y_im      (s0_b_im),
    .out_valid (s0_valid)
  );

  always_ff @(posedge clk) begin
    if (bf_valid) begin
      s0_a_re <= {{(fft_pkg::S0_W - fft_pkg::BF0_W){bf_sum_re[fft_pkg::BF0_W-1]}}, bf_sum_re};
      s0_a_im <= {{(fft_pkg::S0_W - fft_pkg::BF0_W){bf_sum_im[fft_pkg::BF0_W-1]}}, bf_sum_im};
    end
  end

endmodule

// File: hdl/fft_stage_control.sv
`timescale 1ns/10ps

module fft_stage_control (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   s0_valid,
  output logic                                   comm_swap,
  output logic                                   c1_valid,
  output logic [$clog2(fft_pkg::PAIRS)-1:0]      tw1_index
);

  // Stage 0 strobes counted modulo PAIRS
  logic [$clog2(fft_pkg::PAIRS)-1:0] pair_cnt;
  fft_pkg::frame_state_t             state;

  ////////////////////////////////////////////////////////////
  // Frame counter and fill FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pair_cnt <= '0;
      state    <= fft_pkg::FRAME_IDLE;
    end else if (s0_valid) begin
      pair_cnt <= pair_cnt + 1'b1;
      case (state)
        fft_pkg::FRAME_IDLE: begin
          state <= fft_pkg::FRAME_FILL;
        end
        fft_pkg::FRAME_FILL: begin
          // Last strobe of the commutator fill
          if (pair_cnt == ($clog2(fft_pkg::PAIRS))'(fft_pkg::COMM_DEPTH - 1)) begin
            state <= fft_pkg::FRAME_RUN;
          end
        end
        default: begin
          state <= fft_pkg::FRAME_RUN;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Commutator and stage 1 controls
  ////////////////////////////////////////////////////////////

  // High for pairs 4..7 of each group of 8
  assign comm_swap = pair_cnt[2];

  // Before the delay lines are full the commutator output is stale
  assign c1_valid = s0_valid && (state == fft_pkg::FRAME_RUN);

  // Output position m is the low two count bits, twiddle index is 2m
  assign tw1_index = {pair_cnt[1:0], 1'b0};

endmodule

// File: hdl/fft_delay_commutator.sv
`timescale 1ns/10ps

module fft_delay_commutator (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            comm_shift,
  input  logic                            comm_swap,
  input  logic signed [fft_pkg::S0_W-1:0] s0_a_re,
  input  logic signed [fft_pkg::S0_W-1:0] s0_a_im,
  input  logic signed [fft_pkg::S0_W-1:0] s0_b_re,
  input  logic signed [fft_pkg::S0_W-1:0] s0_b_im,
  output logic signed [fft_pkg::S0_W-1:0] c1_a_re,
  output logic signed [fft_pkg::S0_W-1:0] c1_a_im,
  output logic signed [fft_pkg::S0_W-1:0] c1_b_re,
  output logic signed [fft_pkg::S0_W-1:0] c1_b_im
);

  // Lane b delay ahead of the switch
  logic signed [fft_pkg::S0_W-1:0] b_dly_re [fft_pkg::COMM_DEPTH];
  logic signed [fft_pkg::S0_W-1:0] b_dly_im [fft_pkg::COMM_DEPTH];
  // Lane a delay behind the switch
  logic signed [fft_pkg::S0_W-1:0] a_dly_re [fft_pkg::COMM_DEPTH];
  logic signed [fft_pkg::S0_W-1:0] a_dly_im [fft_pkg::COMM_DEPTH];

  // Switch outputs
  logic signed [fft_pkg::S0_W-1:0] top_re;
  logic signed [fft_pkg::S0_W-1:0] top_im;

  ////////////////////////////////////////////////////////////
  // Switch
  ////////////////////////////////////////////////////////////

  // Second half of a group: undelayed a and delayed b trade places
  assign top_re  = comm_swap ? b_dly_re[fft_pkg::COMM_DEPTH-1] : s0_a_re;
  assign top_im  = comm_swap ? b_dly_im[fft_pkg::COMM_DEPTH-1] : s0_a_im;
  assign c1_b_re = comm_swap ? s0_a_re : b_dly_re[fft_pkg::COMM_DEPTH-1];
  assign c1_b_im = comm_swap ? s0_a_im : b_dly_im[fft_pkg::COMM_DEPTH-1];

  assign c1_a_re = a_dly_re[fft_pkg::COMM_DEPTH-1];
  assign c1_a_im = a_dly_im[fft_pkg::COMM_DEPTH-1];

  ////////////////////////////////////////////////////////////
  // Delay lines, advanced once per stage 0 pair
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < fft_pkg::COMM_DEPTH; i++) begin
        b_dly_re[i] <= '0;
        b_dly_im[i] <= '0;
        a_dly_re[i] <= '0;
        a_dly_im[i] <= '0;
      end
    end else if (comm_shift) begin
      b_dly_re[0] <= s0_b_re;
      b_dly_im[0] <= s0_b_im;
      a_dly_re[0] <= top_re;
      a_dly_im[0] <= top_im;
      for (int i = 1; i < fft_pkg::COMM_DEPTH; i++) begin
        b_dly_re[i] <= b_dly_re[i-1];
        b_dly_im[i] <= b_dly_im[i-1];
        a_dly_re[i] <= a_dly_re[i-1];
        a_dly_im[i] <= a_dly_im[i-1];
      end
    end
  end

endmodule

// File: hdl/fft_output_stage.sv
`timescale 1ns/10ps

module fft_output_stage (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              c1_valid,
  input  logic [$clog2(fft_pkg::PAIRS)-1:0] tw1_index,
  input  logic signed [fft_pkg::S0_W-1:0]   c1_a_re,
  input  logic signed [fft_pkg::S0_W-1:0]   c1_a_im,
  input  logic signed [fft_pkg::S0_W-1:0]   c1_b_re,
  input  logic signed [fft_pkg::S0_W-1:0]   c1_b_im,
  output logic                              out_valid,
  output logic signed [fft_pkg::OUT_W-1:0]  out_a_re,
  output logic signed [fft_pkg::OUT_W-1:0]  out_a_im,
  output logic signed [fft_pkg::OUT_W-1:0]  out_b_re,
  output logic signed [fft_pkg::OUT_W-1:0]  out_b_im
);

  logic                              bf_valid;
  logic [$clog2(fft_pkg::PAIRS)-1:0] bf_idx;
  logic signed [fft_pkg::BF1_W-1:0]  bf_sum_re;
  logic signed [fft_pkg::BF1_W-1:0]  bf_sum_im;
  logic signed [fft_pkg::BF1_W-1:0]  bf_dif_re;
  logic signed [fft_pkg::BF1_W-1:0]  bf_dif_im;
  logic signed [fft_pkg::S1_W-1:0]   sum_d_re;
  logic signed [fft_pkg::S1_W-1:0]   sum_d_im;
  logic signed [fft_pkg::S1_W-1:0]   rot_re;
  logic signed [fft_pkg::S1_W-1:0]   rot_im;

  // Clamp to the signed OUT_W range
  function automatic logic signed [fft_pkg::OUT_W-1:0] saturate(
    input logic signed [fft_pkg::S1_W-1:0] v
  );
    logic top_bits_same;
    top_bits_same = &v[fft_pkg::S1_W-1:fft_pkg::OUT_W-1] ||
                    ~|v[fft_pkg::S1_W-1:fft_pkg::OUT_W-1];
    if (top_bits_same) begin
      return v[fft_pkg::OUT_W-1:0];
    end
    return {v[fft_pkg::S1_W-1], {(fft_pkg::OUT_W-1){~v[fft_pkg::S1_W-1]}}};
  endfunction

  ////////////////////////////////////////////////////////////
  // Stage 1 butterfly
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bf_valid <= 1'b0;
    end else begin
      bf_valid <= c1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (c1_valid) begin
      bf_sum_re <= c1_a_re + c1_b_re;
      bf_sum_im <= c1_a_im + c1_b_im;
      bf_dif_re <= c1_a_re - c1_b_re;
      bf_dif_im <= c1_a_im - c1_b_im;
      bf_idx    <= tw1_index;
    end
  end

  // Difference rotated by W16^(2m), sum waits one register
  fft_cmult_round #(
    .DATA_W (fft_pkg::BF1_W)
  ) u_rot1 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (bf_valid),
    .x_re      (bf_dif_re),
    .x_im      (bf_dif_im),
    .w_re      (fft_pkg::TW_RE[bf_idx]),
    .w_im      (fft_pkg::TW_IM[bf_idx]),
    .y_re      (rot_re),
    .y_im      (rot_im),
    .out_valid (out_valid)
  );

  always_ff @(posedge clk) begin
    if (bf_valid) begin
      sum_d_re <= {{(fft_pkg::S1_W - fft_pkg::BF1_W){bf_sum_re[fft_pkg::BF1_W-1]}}, bf_sum_re};
      sum_d_im <= {{(fft_pkg::S1_W - fft_pkg::BF1_W){bf_sum_im[fft_pkg::BF1_W-1]}}, bf_sum_im};
    end
  end

  ////////////////////////////////////////////////////////////
  // Output saturation
  ////////////////////////////////////////////////////////////

  assign out_a_re = saturate(sum_d_re);
  assign out_a_im = saturate(sum_d_im);
  assign out_b_re = saturate(rot_re);
  assign out_b_im = saturate(rot_im);

endmodule

// File: hdl/fft_two_stage_top.sv
`timescale 1ns/10ps

module fft_two_stage_top (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             in_valid,
  input  logic signed [fft_pkg::IN_W-1:0]  in_a_re,
  input  logic signed [fft_pkg::IN_W-1:0]  in_a_im,
  input  logic signed [fft_pkg::IN_W-1:0]  in_b_re,
  input  logic signed [fft_pkg::IN_W-1:0]  in_b_im,
  output logic                             out_valid,
  output logic signed [fft_pkg::OUT_W-1:0] out_a_re,
  output logic signed [fft_pkg::OUT_W-1:0] out_a_im,
  output logic signed [fft_pkg::OUT_W-1:0] out_b_re,
  output logic signed [fft_pkg::OUT_W-1:0] out_b_im
);

  // Stage 0 results
  logic                              s0_valid;
  logic signed [fft_pkg::S0_W-1:0]   s0_a_re;
  logic signed [fft_pkg::S0_W-1:0]   s0_a_im;
  logic signed [fft_pkg::S0_W-1:0]   s0_b_re;
  logic signed [fft_pkg::S0_W-1:0]   s0_b_im;

  // Control
  logic                              comm_swap;
  logic                              c1_valid;
  logic [$clog2(fft_pkg::PAIRS)-1:0] tw1_index;

  // Regrouped pairs for stage 1
  logic signed [fft_pkg::S0_W-1:0]   c1_a_re;
  logic signed [fft_pkg::S0_W-1:0]   c1_a_im;
  logic signed [fft_pkg::S0_W-1:0]   c1_b_re;
  logic signed [fft_pkg::S0_W-1:0]   c1_b_im;

  ////////////////////////////////////////////////////////////
  // Stage 0
  ////////////////////////////////////////////////////////////

  fft_input_stage u_input_stage (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_a_re  (in_a_re),
    .in_a_im  (in_a_im),
    .in_b_re  (in_b_re),
    .in_b_im  (in_b_im),
    .s0_valid (s0_valid),
    .s0_a_re  (s0_a_re),
    .s0_a_im  (s0_a_im),
    .s0_b_re  (s0_b_re),
    .s0_b_im  (s0_b_im)
  );

  fft_stage_control u_stage_control (
    .clk       (clk),
    .rst_n     (rst_n),
    .s0_valid  (s0_valid),
    .comm_swap (comm_swap),
    .c1_valid  (c1_valid),
    .tw1_index (tw1_index)
  );

  ////////////////////////////////////////////////////////////
  // Stage 1
  ////////////////////////////////////////////////////////////

  // Delay lines advance on every stage 0 pair
  fft_delay_commutator u_commutator (
    .clk        (clk),
    .rst_n      (rst_n),
    .comm_shift (s0_valid),
    .comm_swap  (comm_swap),
    .s0_a_re    (s0_a_re),
    .s0_a_im    (s0_a_im),
    .s0_b_re    (s0_b_re),
    .s0_b_im    (s0_b_im),
    .c1_a_re    (c1_a_re),
    .c1_a_im    (c1_a_im),
    .c1_b_re    (c1_b_re),
    .c1_b_im    (c1_b_im)
  );

  fft_output_stage u_output_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .c1_valid  (c1_valid),
    .tw1_index (tw1_index),
    .c1_a_re   (c1_a_re),
    .c1_a_im   (c1_a_im),
    .c1_b_re   (c1_b_re),
    .c1_b_im   (c1_b_im),
    .out_valid (out_valid),
    .out_a_re  (out_a_re),
    .out_a_im  (out_a_im),
    .out_b_re  (out_b_re),
    .out_b_im  (out_b_im)
  );

endmodule

// File: bench/fft_ref_model.svh
`ifndef FFT_REF_MODEL_SVH
`define FFT_REF_MODEL_SVH

////////////////////////////////////////////////////////////
// Reference arithmetic for the two FFT stages
////////////////////////////////////////////////////////////

// Round half up, then drop the twiddle fraction bits
function automatic int round_scale(input longint acc);
  longint half;
  half = longint'(1) <<< (fft_pkg::COEFF_FRAC - 1);
  return int'((acc + half) >>> fft_pkg::COEFF_FRAC);
endfunction

// Clamp to the signed output range
function automatic int clamp_out(input int v);
  int hi;
  int lo;
  hi = (1 << (fft_pkg::OUT_W - 1)) - 1;
  lo = -(1 << (fft_pkg::OUT_W - 1));
  if (v > hi) begin
    return hi;
  end
  if (v < lo) begin
    return lo;
  end
  return v;
endfunction

task automatic butterfly(input int a_re, input int a_im, input int b_re, input int b_im,
                         output int s_re, output int s_im, output int d_re, output int d_im);
  s_re = a_re + b_re;
  s_im = a_im + b_im;
  d_re = a_re - b_re;
  d_im = a_im - b_im;
endtask

// Multiply by W16^k from the twiddle tables
task automatic rotate(input int x_re, input int x_im, input int k,
                      output int y_re, output int y_im);
  longint w_re;
  longint w_im;
  w_re = longint'(fft_pkg::TW_RE[k]);
  w_im = longint'(fft_pkg::TW_IM[k]);
  y_re = round_scale(x_re * w_re - x_im * w_im);
  y_im = round_scale(x_re * w_im + x_im * w_re);
endtask

// One 16 point frame in, eight output pairs out in DUT order
task automatic model_frame(input int x_re [16], input int x_im [16],
                           output int y_a_re [8], output int y_a_im [8],
                           output int y_b_re [8], output int y_b_im [8]);
  // Lane 0 holds a', lane 1 holds b'
  int s0_re [2][8];
  int s0_im [2][8];
  int d_re;
  int d_im;
  int s_re;
  int s_im;
  int r_re;
  int r_im;
  int k;
  for (int n = 0; n < fft_pkg::PAIRS; n++) begin
    butterfly(x_re[n], x_im[n], x_re[n+8], x_im[n+8],
              s0_re[0][n], s0_im[0][n], d_re, d_im);
    rotate(d_re, d_im, n, s0_re[1][n], s0_im[1][n]);
  end
  // Stage 1 emits the a' group first, then the b' group
  for (int g = 0; g < 2; g++) begin
    for (int m = 0; m < fft_pkg::COMM_DEPTH; m++) begin
      k = g * fft_pkg::COMM_DEPTH + m;
      butterfly(s0_re[g][m], s0_im[g][m], s0_re[g][m+4], s0_im[g][m+4],
                s_re, s_im, d_re, d_im);
      rotate(d_re, d_im, 2 * m, r_re, r_im);
      y_a_re[k] = clamp_out(s_re);
      y_a_im[k] = clamp_out(s_im);
      y_b_re[k] = clamp_out(r_re);
      y_b_im[k] = clamp_out(r_im);
    end
  end
endtask

`endif

// File: bench/tb_fft_two_stage.sv
`timescale 1ns/10ps

module tb_fft_two_stage;

  typedef enum logic [1:0] {
    PAT_IMPULSE,
    PAT_CONSTANT,
    PAT_RANDOM,
    PAT_FULL_SCALE
  } pattern_t;

  typedef enum logic {
    GAP_DENSE,
    GAP_RANDOM
  } gap_t;

  typedef struct packed {
    pattern_t   kind;
    gap_t       gaps;
    logic [7:0] frames;
    logic [7:0] exp_outputs;
  } test_entry_t;

  // Every pair sent after the commutator fill yields one output pair
  test_entry_t test_table [8] = '{
    '{PAT_IMPULSE,    GAP_DENSE,  8'd1, 8'd8},
    '{PAT_CONSTANT,   GAP_DENSE,  8'd1, 8'd8},
    '{PAT_RANDOM,     GAP_DENSE,  8'd2, 8'd16},
    '{PAT_FULL_SCALE, GAP_DENSE,  8'd4, 8'd32},
    '{PAT_RANDOM,     GAP_RANDOM, 8'd2, 8'd16},
    '{PAT_RANDOM,     GAP_DENSE,  8'd4, 8'd32},
    '{PAT_CONSTANT,   GAP_RANDOM, 8'd3, 8'd24},
    '{PAT_FULL_SCALE, GAP_RANDOM, 8'd1, 8'd8}
  };

  logic                             clk;
  logic                             rst_n;
  logic                             in_valid;
  logic signed [fft_pkg::IN_W-1:0]  in_a_re;
  logic signed [fft_pkg::IN_W-1:0]  in_a_im;
  logic signed [fft_pkg::IN_W-1:0]  in_b_re;
  logic signed [fft_pkg::IN_W-1:0]  in_b_im;
  logic                             out_valid;
  logic signed [fft_pkg::OUT_W-1:0] out_a_re;
  logic signed [fft_pkg::OUT_W-1:0] out_a_im;
  logic signed [fft_pkg::OUT_W-1:0] out_b_re;
  logic signed [fft_pkg::OUT_W-1:0] out_b_im;

  // Expected output pairs, packed a_re, a_im, b_re, b_im
  logic [4*fft_pkg::OUT_W-1:0] exp_q [$];
  int          frame_re [16];
  int          frame_im [16];
  logic [31:0] data_state;
  logic [31:0] gap_state;
  int          error_count;
  int          tests_failed;
  int          out_count;
  int          cur_test;

  `include "fft_ref_model.svh"

  fft_two_stage_top DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_a_re   (in_a_re),
    .in_a_im   (in_a_im),
    .in_b_re   (in_b_re),
    .in_b_im   (in_b_im),
    .out_valid (out_valid),
    .out_a_re  (out_a_re),
    .out_a_im  (out_a_im),
    .out_b_re  (out_b_re),
    .out_b_im  (out_b_im)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic compare_sample(input string name,
                                input logic signed [fft_pkg::OUT_W-1:0] actual,
                                input logic signed [fft_pkg::OUT_W-1:0] expected);
    if (actual !== expected) begin
      error_count++;
      $display("MISMATCH %s: got 0x%h, expected 0x%h (test %0d, output %0d)",
               name, actual, expected, cur_test, out_count);
    end
  endtask

  task automatic compare_count(input string name, input int actual, input int expected);
    if (actual != expected) begin
      error_count++;
      $display("MISMATCH %s: got 0x%h, expected 0x%h (test %0d)",
               name, actual, expected, cur_test);
    end
  endtask

  // Outputs are sampled half a cycle after the DUT registers update
  always @(negedge clk) begin : check_outputs
    logic [4*fft_pkg::OUT_W-1:0] exp_word;
    if (rst_n && out_valid) begin
      out_count++;
      if (exp_q.size() == 0) begin
        error_count++;
        $display("ERROR: test %0d gave an extra output pair that no frame accounts for",
                 cur_test);
      end else begin
        exp_word = exp_q.pop_front();
        compare_sample("out_a_re", out_a_re, exp_word[3*fft_pkg::OUT_W +: fft_pkg::OUT_W]);
        compare_sample("out_a_im", out_a_im, exp_word[2*fft_pkg::OUT_W +: fft_pkg::OUT_W]);
        compare_sample("out_b_re", out_b_re, exp_word[fft_pkg::OUT_W +: fft_pkg::OUT_W]);
        compare_sample("out_b_im", out_b_im, exp_word[0 +: fft_pkg::OUT_W]);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic apply_reset();
    @(negedge clk);
    rst_n    = 1'b0;
    in_valid = 1'b0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic check_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      if (out_valid !== 1'b0) begin
        error_count++;
        $display("ERROR: out_valid went high after reset with no input sent (test %0d)",
                 cur_test);
      end
    end
  endtask

  // Called on a falling edge; leaves in_valid low on return
  task automatic drive_pair(input int a_re, input int a_im, input int b_re, input int b_im,
                            input logic gappy);
    int idle;
    if (gappy) begin
      gap_state = xorshift32(gap_state);
      idle = int'(gap_state[1:0]);
      repeat (idle) @(negedge clk);
    end
    in_valid = 1'b1;
    in_a_re  = a_re[fft_pkg::IN_W-1:0];
    in_a_im  = a_im[fft_pkg::IN_W-1:0];
    in_b_re  = b_re[fft_pkg::IN_W-1:0];
    in_b_im  = b_im[fft_pkg::IN_W-1:0];
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic build_frame(input pattern_t kind, input int f);
    logic negate;
    logic re_pos;
    logic im_pos;
    for (int i = 0; i < fft_pkg::FFT_POINTS; i++) begin
      case (kind)
        PAT_IMPULSE: begin
          frame_re[i] = (i == 0) ? 400 : 0;
          frame_im[i] = (i == 0) ? -300 : 0;
        end
        PAT_CONSTANT: begin
          frame_re[i] = 150 + 40 * f;
          frame_im[i] = -90 + 25 * f;
        end
        PAT_RANDOM: begin
          data_state  = xorshift32(data_state);
          frame_re[i] = int'($signed(data_state[9:0]));
          frame_im[i] = int'($signed(data_state[25:16]));
        end
        default: begin
          negate = ((f / 2) % 2) == 1;
          if (f % 2 == 0) begin
            // Opposite halves drive the stage 1 difference past OUT_W
            re_pos = ((i % 8) < 4) ^ negate;
            im_pos = re_pos;
          end else begin
            // Second half differences a quarter turn ahead, so the b' group sums overflow
            re_pos = ((i < 8) == ((i % 8) < 4)) ^ negate;
            im_pos = (i < 8) ^ negate;
          end
          frame_re[i] = re_pos ? 511 : -512;
          frame_im[i] = im_pos ? 511 : -512;
        end
      endcase
    end
  endtask

  task automatic drain_outputs();
    int waited;
    waited = 0;
    while (exp_q.size() > 0 && waited < 64) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() > 0) begin
      error_count++;
      $display("ERROR: test %0d ended with %0d expected output pairs never produced",
               cur_test, exp_q.size());
      exp_q.delete();
    end
    // Time for any stray strobe to show up
    repeat (12) @(negedge clk);
  endtask

  task automatic run_test(input int t);
    int   errors_before;
    logic gappy;
    int   exp_a_re [8];
    int   exp_a_im [8];
    int   exp_b_re [8];
    int   exp_b_im [8];
    cur_test      = t;
    errors_before = error_count;
    gappy         = (test_table[t].gaps == GAP_RANDOM);
    apply_reset();
    out_count = 0;
    check_idle(20);
    // Same seed each test, so dense and gapped runs see the same frames
    data_state = 32'h9a00;
    for (int f = 0; f < int'(test_table[t].frames); f++) begin
      build_frame(test_table[t].kind, f);
      model_frame(frame_re, frame_im, exp_a_re, exp_a_im, exp_b_re, exp_b_im);
      for (int k = 0; k < fft_pkg::PAIRS; k++) begin
        exp_q.push_back({exp_a_re[k][fft_pkg::OUT_W-1:0], exp_a_im[k][fft_pkg::OUT_W-1:0],
                         exp_b_re[k][fft_pkg::OUT_W-1:0], exp_b_im[k][fft_pkg::OUT_W-1:0]});
      end
      for (int n = 0; n < fft_pkg::PAIRS; n++) begin
        drive_pair(frame_re[n], frame_im[n], frame_re[n+8], frame_im[n+8], gappy);
      end
    end
    // Four more pairs push the last b' group out of the commutator
    for (int n = 0; n < fft_pkg::COMM_DEPTH; n++) begin
      drive_pair(0, 0, 0, 0, gappy);
    end
    drain_outputs();
    compare_count("out_valid count", out_count, int'(test_table[t].exp_outputs));
    if (error_count != errors_before) begin
      tests_failed++;
    end
    $display("test %0d %s %s frames=%0d outputs=%0d : %s", t, test_table[t].kind.name(),
             test_table[t].gaps.name(), test_table[t].frames, out_count,
             (error_count == errors_before) ? "ok" : "errors");
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    in_a_re      = '0;
    in_a_im      = '0;
    in_b_re      = '0;
    in_b_im      = '0;
    error_count  = 0;
    tests_failed = 0;
    out_count    = 0;
    cur_test     = 0;
    data_state   = 32'h9a00;
    gap_state    = 32'h9a00;
    for (int t = 0; t < $size(test_table); t++) begin
      run_test(t);
    end
    $display("%0d tests run, %0d failed, %0d errors", $size(test_table), tests_failed,
             error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    int limit_cycles;
    limit_cycles = 0;
    for (int t = 0; t < $size(test_table); t++) begin
      limit_cycles += 4 * 40 * int'(test_table[t].frames);
    end
    repeat (limit_cycles) @(posedge clk);
    $display("ERROR: run still busy after %0d cycles, stopped by the watchdog", limit_cycles);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: tb.f
+incdir+bench
hdl/fft_pkg.sv
hdl/fft_cmult_round.sv
hdl/fft_input_stage.sv
hdl/fft_stage_control.sv
hdl/fft_delay_commutator.sv
hdl/fft_output_stage.sv
hdl/fft_two_stage_top.sv
bench/tb_fft_two_stage.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
TOP       := tb_fft_two_stage
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@! grep -q "TESTS FAILED" $(LOG)
	@grep -q "TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
